// ==== Makefile ====
# Verilator build and run of the trap checker testbench.
# The binary exits with a failing status when the testbench stops on $fatal.

SRCS := $(wildcard hw/*.sv dv/*.sv)

run: obj_dir/Vtb_trap_checker
	./obj_dir/Vtb_trap_checker

# Rebuilt only when a source file or the file list changes
obj_dir/Vtb_trap_checker: flist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  -f flist.f --top-module tb_trap_checker -Mdir obj_dir

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== dv/tb_trap_checker.sv ====
/*
  Testbench for the trap checker. Drives retirements, cause writes and
  step control on falling edges, answers reports with a random-delay
  acknowledge, and compares each report with a reference model.
*/

`timescale 1ns/100ps
`default_nettype none

module tb_trap_checker import trap_check_pkg::*; ();

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;

  logic      clk;
  logic      rst_n;
  retire_t   retire;
  cause_wr_t cause_wr;
  logic      step;
  logic      debug_mode;
  logic      report_ack;
  report_t   report;
  logic      report_req;
  logic      slow_ack;
  integer    seed = 32'hea88dd86;

  // Reference model state with first records per class and the step window count
  logic        exp_found [NUM_CLASSES];
  logic [31:0] exp_pc    [NUM_CLASSES];
  logic        act_found [NUM_CLASSES];
  logic [31:0] act_pc    [NUM_CLASSES];
  logic        checked   [NUM_CLASSES];
  int          step_count;
  report_t     exp_q [$];

  trap_checker_top trap_checker_top_i (
    .clk          (clk),
    .rst_ni       (rst_n),
    .retire_i     (retire),
    .cause_wr_i   (cause_wr),
    .step_i       (step),
    .debug_mode_i (debug_mode),
    .report_ack_i (report_ack),
    .report_o     (report),
    .report_req_o (report_req)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Flags come as {mpu, bus, illegal, ecall, ebreak} and the lowest class wins
  function automatic int class_of(input logic [4:0] flags);
    int cls;
    cls = -1;
    for (int i = NUM_CLASSES - 1; i >= 0; i--) begin
      if (flags[4-i]) cls = i;
    end
    return cls;
  endfunction

  function automatic int class_of_code(input logic [4:0] code);
    case (code)
      5'd1:    return 0;
      5'd24:   return 1;
      5'd2:    return 2;
      5'd11:   return 3;
      5'd3:    return 4;
      default: return -1;
    endcase
  endfunction

  function automatic logic [4:0] code_of_class(input int cls);
    case (cls)
      0:       return 5'd1;
      1:       return 5'd24;
      2:       return 5'd2;
      3:       return 5'd11;
      default: return 5'd3;
    endcase
  endfunction

  function automatic logic [31:0] rand_pc();
    logic [31:0] pc;
    pc = $random(seed);
    pc[1:0] = 2'b00;
    return pc;
  endfunction

  // A class is compared once, as soon as both of its records exist
  task automatic compare_class(input int c);
    report_t r;
    if (exp_found[c] && act_found[c] && !checked[c]) begin
      checked[c] = 1'b1;
      if (exp_pc[c] != act_pc[c]) begin
        r.kind     = RPT_MEPC;
        r.cls      = exc_class_e'(3'(c));
        r.expected = exp_pc[c];
        r.actual   = act_pc[c];
        exp_q.push_back(r);
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic retire_insn(input logic [31:0] pc, input logic [4:0] flags,
                             input logic kill);
    int      c;
    report_t r;
    retire.valid   = 1'b1;
    retire.kill    = kill;
    retire.pc      = pc;
    retire.mpu_err = flags[4];
    retire.bus_err = flags[3];
    retire.illegal = flags[2];
    retire.ecall   = flags[1];
    retire.ebreak  = flags[0];
    c = class_of(flags);
    if (!kill && c >= 0 && !exp_found[c]) begin
      exp_found[c] = 1'b1;
      exp_pc[c]    = pc;
      compare_class(c);
    end
    // Killed retirements count while stepping as well
    if (step && !debug_mode) begin
      if (step_count == 1) begin
        r.kind     = RPT_STEP;
        r.cls      = CLS_MPU_FAULT;
        r.expected = '0;
        r.actual   = '0;
        exp_q.push_back(r);
      end
      if (step_count < 2) step_count++;
    end
    @(negedge clk);
    retire = '0;
  endtask

  task automatic write_cause(input logic intr, input logic [4:0] code,
                             input logic [31:0] mepc);
    int c;
    cause_wr.valid     = 1'b1;
    cause_wr.interrupt = intr;
    cause_wr.code      = code;
    cause_wr.mepc      = mepc;
    c = class_of_code(code);
    if (!intr && c >= 0 && !act_found[c]) begin
      act_found[c] = 1'b1;
      act_pc[c]    = mepc;
      compare_class(c);
    end
    @(negedge clk);
    cause_wr = '0;
  endtask

  // Debug entry closes the current step window
  task automatic debug_pulse();
    debug_mode = 1'b1;
    step_count = 0;
    @(negedge clk);
    debug_mode = 1'b0;
  endtask

  task automatic apply_reset();
    rst_n    = 1'b0;
    retire   = '0;
    cause_wr = '0;
    step     = 1'b0;
    for (int i = 0; i < NUM_CLASSES; i++) begin
      exp_found[i] = 1'b0;
      act_found[i] = 1'b0;
      checked[i]   = 1'b0;
    end
    step_count = 0;
    exp_q.delete();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want));
    end
  endtask

  // Give the FSM time to finish, then wait until every expected report is out
  task automatic wait_drained();
    int n;
    n = 0;
    repeat (8) @(negedge clk);
    while ((exp_q.size() != 0 || report_req || report_ack) && n < 150) begin
      @(negedge clk);
      n++;
    end
    if (n < 150) repeat (8) @(negedge clk);
    else fail_run("An expected report never arrived from the DUT");
  endtask

  // Receiver side of the four-phase handshake
  initial begin : ack_model
    int delay;
    report_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (report_req && !report_ack) begin
        delay = slow_ack ? 7 : $unsigned($random(seed)) % 8;
        repeat (delay) @(negedge clk);
        report_ack = 1'b1;
        while (report_req) @(negedge clk);
        report_ack = 1'b0;
      end
    end
  end

  // Each rise of the request is checked against the head of the expected queue
  initial begin : compare_reports
    report_t want;
    logic    req_seen;
    logic    rose;
    req_seen = 1'b0;
    forever begin
      @(negedge clk);
      rose     = report_req && !req_seen;
      req_seen = report_req;
      if (rose) begin
        if (exp_q.size() == 0) begin
          fail_run("The DUT sent a report that the model did not expect");
        end else begin
          want = exp_q.pop_front();
          check_value("report_o.kind", 32'(report.kind), 32'(want.kind));
          check_value("report_o.cls", 32'(report.cls), 32'(want.cls));
          check_value("report_o.expected", report.expected, want.expected);
          check_value("report_o.actual", report.actual, want.actual);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    fail_run("The run did not finish within the cycle budget");
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin : run_tests
    logic [31:0] pc;
    rst_n      = 1'b0;
    retire     = '0;
    cause_wr   = '0;
    step       = 1'b0;
    debug_mode = 1'b0;
    slow_ack   = 1'b0;

    // Matching mepc for every class gives no report
    apply_reset();
    for (int c = 0; c < NUM_CLASSES; c++) begin
      pc = rand_pc();
      retire_insn(pc, 5'b10000 >> c, 1'b0);
      write_cause(1'b0, code_of_class(c), pc);
    end
    wait_drained();

    // Mismatches where the cause write comes first on odd classes
    apply_reset();
    for (int c = 0; c < NUM_CLASSES; c++) begin
      pc = rand_pc();
      if (c % 2 == 1) write_cause(1'b0, code_of_class(c), pc + 32'(4 * (c + 1)));
      retire_insn(pc, 5'b10000 >> c, 1'b0);
      if (c % 2 == 0) write_cause(1'b0, code_of_class(c), pc + 32'(4 * (c + 1)));
    end
    wait_drained();

    // Several flags count only for the highest class
    // Lower class writes carry another mepc so a wrong capture would report
    apply_reset();
    pc = rand_pc();
    retire_insn(pc, 5'b11111, 1'b0);
    write_cause(1'b0, code_of_class(1), pc + 32'd4);
    write_cause(1'b0, code_of_class(0), pc + 32'd8);
    pc = rand_pc();
    retire_insn(pc, 5'b00101, 1'b0);
    write_cause(1'b0, code_of_class(4), pc + 32'd4);
    write_cause(1'b0, code_of_class(2), pc);
    wait_drained();

    // Killed retirements, interrupts, unknown codes and repeats change nothing
    apply_reset();
    retire_insn(32'h0000_1000, 5'b00100, 1'b1);
    write_cause(1'b1, code_of_class(2), 32'h0000_1000);
    write_cause(1'b0, 5'd7, 32'h0000_2000);
    retire_insn(32'h0000_2004, 5'b10000, 1'b0);
    retire_insn(32'h0000_3000, 5'b00100, 1'b0);
    retire_insn(32'h0000_3004, 5'b00100, 1'b0);
    write_cause(1'b0, code_of_class(2), 32'h0000_3000);
    write_cause(1'b0, code_of_class(2), 32'h0000_3008);
    write_cause(1'b0, code_of_class(3), 32'h0000_4000);
    write_cause(1'b0, code_of_class(3), 32'h0000_4004);
    retire_insn(32'h0000_4000, 5'b00010, 1'b0);
    retire_insn(32'h0000_5000, 5'b00001, 1'b1);
    retire_insn(32'h0000_5004, 5'b00001, 1'b0);
    write_cause(1'b0, code_of_class(4), 32'h0000_5000);
    wait_drained();

    // Two retirements in one step window overrun but one per window does not
    apply_reset();
    step = 1'b1;
    retire_insn(32'h0000_6000, 5'b00000, 1'b0);
    retire_insn(32'h0000_6004, 5'b00000, 1'b0);
    debug_pulse();
    wait_drained();
    retire_insn(32'h0000_6008, 5'b00000, 1'b0);
    debug_pulse();
    retire_insn(32'h0000_600c, 5'b00000, 1'b0);
    debug_pulse();
    step = 1'b0;
    wait_drained();

    // A slow receiver with all classes pending and the step overrun queued behind them
    apply_reset();
    slow_ack = 1'b1;
    for (int c = 0; c < NUM_CLASSES; c++) begin
      retire_insn(32'h0001_0000 + 32'(16 * c), 5'b10000 >> c, 1'b0);
    end
    for (int c = 0; c < NUM_CLASSES; c++) begin
      write_cause(1'b0, code_of_class(c), 32'h0002_0000 + 32'(16 * c));
    end
    step = 1'b1;
    retire_insn(32'h0003_0000, 5'b00000, 1'b0);
    retire_insn(32'h0003_0004, 5'b00000, 1'b0);
    step = 1'b0;
    wait_drained();
    slow_ack = 1'b0;

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/trap_check_pkg.sv
hw/expect_capture.sv
hw/cause_capture.sv
hw/step_counter.sv
hw/report_fsm.sv
hw/trap_checker_top.sv
dv/tb_trap_checker.sv

// ==== hw/cause_capture.sv ====
/*
  Records, per exception class, the mepc value of the first trap-cause
  write that reports that class. Interrupt causes and codes outside
  the five checked classes are ignored.
*/

`timescale 1ns/100ps
`default_nettype none

module cause_capture import trap_check_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_ni,
  input  cause_wr_t cause_wr_i,
  output class_pc_t [NUM_CLASSES-1:0] act_rec_o
);

  logic                   known;
  exc_class_e             cls;
  logic [NUM_CLASSES-1:0] set_vec;
  logic [NUM_CLASSES-1:0] found_q;
  logic [XLEN-1:0]        mepc_q [NUM_CLASSES];

  // Map the cause code back onto a class
  always_comb begin
    known   = 1'b1;
    cls     = CLS_MPU_FAULT;
    set_vec = '0;
    case (cause_wr_i.code)
      EXC_CAUSE_INSTR_FAULT:     cls = CLS_MPU_FAULT;
      EXC_CAUSE_INSTR_BUS_FAULT: cls = CLS_BUS_FAULT;
      EXC_CAUSE_ILLEGAL_INSN:    cls = CLS_ILLEGAL;
      EXC_CAUSE_ECALL_MMODE:     cls = CLS_ECALL;
      EXC_CAUSE_BREAKPOINT:      cls = CLS_EBREAK;
      default:                   known = 1'b0;
    endcase
    // Interrupt writes share code values with exceptions, so drop them here
    if (cause_wr_i.valid && !cause_wr_i.interrupt && known) begin
      set_vec[cls] = 1'b1;
    end
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | set_vec;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_CLASSES; i++) begin
      if (set_vec[i] && !found_q[i]) begin
        mepc_q[i] <= cause_wr_i.mepc;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_CLASSES; i++) begin
      act_rec_o[i].found = found_q[i];
      act_rec_o[i].pc    = mepc_q[i];
    end
  end

  for (genvar g = 0; g < NUM_CLASSES; g++) begin : g_mepc_chk
    // Later writes of the same class must not disturb the stored value
    a_mepc_frozen : assert property (@(posedge clk) disable iff (!rst_ni)
                                     found_q[g] |=> $stable(mepc_q[g]));
  end

endmodule

`default_nettype wire

// ==== hw/expect_capture.sv ====
/*
  Records, per exception class, the PC of the first retirement that
  must trap for that class. A retirement with several fault flags
  counts only for its highest-priority class.
*/

`timescale 1ns/100ps
`default_nettype none

module expect_capture import trap_check_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_ni,
  input  retire_t   retire_i,
  output class_pc_t [NUM_CLASSES-1:0] exp_rec_o
);

  logic                   hit;
  exc_class_e             cls;
  logic [NUM_CLASSES-1:0] set_vec;
  logic [NUM_CLASSES-1:0] found_q;
  logic [XLEN-1:0]        pc_q [NUM_CLASSES];

  // Priority encode the fault flags, MPU fault wins over everything
  always_comb begin
    hit     = 1'b0;
    cls     = CLS_MPU_FAULT;
    set_vec = '0;
    if (retire_i.valid && !retire_i.kill) begin
      hit = 1'b1;
      if (retire_i.mpu_err) begin
        cls = CLS_MPU_FAULT;
      end else if (retire_i.bus_err) begin
        cls = CLS_BUS_FAULT;
      end else if (retire_i.illegal) begin
        cls = CLS_ILLEGAL;
      end else if (retire_i.ecall) begin
        cls = CLS_ECALL;
      end else if (retire_i.ebreak) begin
        cls = CLS_EBREAK;
      end else begin
        hit = 1'b0;
      end
    end
    if (hit) begin
      set_vec[cls] = 1'b1;
    end
  end

  // Found flags are sticky until reset
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | set_vec;
    end
  end

  // Only the first PC per class is kept
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_CLASSES; i++) begin
      if (set_vec[i] && !found_q[i]) begin
        pc_q[i] <= retire_i.pc;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_CLASSES; i++) begin
      exp_rec_o[i].found = found_q[i];
      exp_rec_o[i].pc    = pc_q[i];
    end
  end

  for (genvar g = 0; g < NUM_CLASSES; g++) begin : g_found_chk
    // A class once found stays found, the FSM relies on this to compare once
    a_found_sticky : assert property (@(posedge clk) disable iff (!rst_ni)
                                      found_q[g] |=> found_q[g]);
  end

endmodule

`default_nettype wire

// ==== hw/report_fsm.sv ====
/*
  Picks classes whose expected and actual records are both present,
  compares them once, and sends mismatches and step overruns out over
  a four-phase req/ack handshake, one report at a time.
*/

`timescale 1ns/100ps
`default_nettype none

module report_fsm import trap_check_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_ni,
  input  class_pc_t [NUM_CLASSES-1:0] exp_rec_i,
  input  class_pc_t [NUM_CLASSES-1:0] act_rec_i,
  input  wire logic step_overrun_i,
  input  wire logic report_ack_i,
  output report_t   report_o,
  output logic      report_req_o,
  output logic      step_clear_o
);

  typedef enum logic [1:0] {IDLE, COMPARE, REQ, WAIT_RELEASE} state_e;

  state_e                 state_q;
  exc_class_e             sel_cls_q;
  report_kind_e           sel_kind_q;
  logic [NUM_CLASSES-1:0] checked_q;
  logic [NUM_CLASSES-1:0] ready;
  logic                   any_ready;
  exc_class_e             pick_cls;
  logic                   send;

  ////////////////////////////////////////
  // Selection
  ////////////////////////////////////////

  // Scan downwards so the lowest ready class ends up selected
  always_comb begin
    any_ready = 1'b0;
    pick_cls  = CLS_MPU_FAULT;
    for (int i = NUM_CLASSES - 1; i >= 0; i--) begin
      ready[i] = exp_rec_i[i].found && act_rec_i[i].found && !checked_q[i];
      if (ready[i]) begin
        any_ready = 1'b1;
        pick_cls  = exc_class_e'(3'(i));
      end
    end
  end

  // A step overrun is always reported, a class only on mismatch
  assign send = (sel_kind_q == RPT_STEP) ||
                (exp_rec_i[sel_cls_q].pc != act_rec_i[sel_cls_q].pc);

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      sel_cls_q  <= CLS_MPU_FAULT;
      sel_kind_q <= RPT_MEPC;
      checked_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (any_ready) begin
            sel_cls_q  <= pick_cls;
            sel_kind_q <= RPT_MEPC;
            state_q    <= COMPARE;
          end else if (step_overrun_i) begin
            sel_cls_q  <= CLS_MPU_FAULT;
            sel_kind_q <= RPT_STEP;
            state_q    <= COMPARE;
          end
        end
        COMPARE: begin
          if (sel_kind_q == RPT_MEPC) begin
            checked_q[sel_cls_q] <= 1'b1;
          end
          state_q <= send ? REQ : IDLE;
        end
        // Request is up, wait for the receiver to take it
        REQ: if (report_ack_i) state_q <= WAIT_RELEASE;
        // Request is down, wait for the receiver to let go
        WAIT_RELEASE: if (!report_ack_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Loaded once per report and held until the ack falls
  always_ff @(posedge clk) begin
    if ((state_q == COMPARE) && send) begin
      report_o.kind     <= sel_kind_q;
      report_o.cls      <= sel_cls_q;
      report_o.expected <= (sel_kind_q == RPT_MEPC) ? exp_rec_i[sel_cls_q].pc : '0;
      report_o.actual   <= (sel_kind_q == RPT_MEPC) ? act_rec_i[sel_cls_q].pc : '0;
    end
  end

  assign report_req_o = (state_q == REQ);
  assign step_clear_o = (state_q == WAIT_RELEASE) && !report_ack_i &&
                        (sel_kind_q == RPT_STEP);

  // The request may only drop once the receiver has answered it
  a_req_held : assert property (@(posedge clk) disable iff (!rst_ni)
                                $fell(report_req_o) |-> $past(report_ack_i));

endmodule

`default_nettype wire

// ==== hw/step_counter.sv ====
/*
  Counts retirements while the core single steps outside debug mode.
  A second retirement in one step window latches an overrun flag,
  which stays set until the report FSM has delivered it.
*/

`timescale 1ns/100ps
`default_nettype none

module step_counter import trap_check_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_ni,
  input  retire_t   retire_i,
  input  wire logic step_i,
  input  wire logic debug_mode_i,
  input  wire logic step_clear_i,
  output logic      step_overrun_o
);

  logic       counted;
  logic [1:0] count_q;

  // Killed retirements still leave the pipeline, so they count too
  assign counted = retire_i.valid && step_i && !debug_mode_i;

  // Saturating count, a new step window starts on each debug entry
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= 2'd0;
    end else if (debug_mode_i) begin
      count_q <= 2'd0;
    end else if (counted && (count_q != 2'd2)) begin
      count_q <= count_q + 2'd1;
    end
  end

  // Set only on the second retirement, so one window gives one report
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      step_overrun_o <= 1'b0;
    end else if (counted && (count_q == 2'd1)) begin
      step_overrun_o <= 1'b1;
    end else if (step_clear_i) begin
      step_overrun_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/trap_check_pkg.sv ====
/*
  Shared widths, cause codes and port types for the trap checker.
  Every checker module imports this package in its header, and the
  testbench uses the same structs to drive and observe the DUT.
*/

`default_nettype none

package trap_check_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int XLEN        = 32;
  localparam int NUM_CLASSES = 5;
  localparam int EXC_CODE_W  = 5;

  // Synchronous exception codes as written to mcause by the core
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_INSTR_FAULT     = 5'd1;
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_ILLEGAL_INSN    = 5'd2;
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_BREAKPOINT      = 5'd3;
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_INSTR_BUS_FAULT = 5'd24;
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_ECALL_MMODE     = 5'd11;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Exception classes, lowest value has the highest priority
  typedef enum logic [2:0] {
    CLS_MPU_FAULT = 3'd0,
    CLS_BUS_FAULT = 3'd1,
    CLS_ILLEGAL   = 3'd2,
    CLS_ECALL     = 3'd3,
    CLS_EBREAK    = 3'd4
  } exc_class_e;

  typedef enum logic {
    RPT_MEPC = 1'b0,
    RPT_STEP = 1'b1
  } report_kind_e;

  // One instruction leaving the write-back stage
  typedef struct packed {
    logic            valid;
    logic            kill;     // Merged suppression (irq ack, pending debug, NMI)
    logic [XLEN-1:0] pc;
    logic            mpu_err;
    logic            bus_err;
    logic            illegal;
    logic            ecall;
    logic            ebreak;
  } retire_t;

  // One save of the trap cause into the CSR file
  typedef struct packed {
    logic                  valid;
    logic                  interrupt;
    logic [EXC_CODE_W-1:0] code;
    logic [XLEN-1:0]       mepc;
  } cause_wr_t;

  typedef struct packed {
    report_kind_e    kind;
    exc_class_e      cls;
    logic [XLEN-1:0] expected;
    logic [XLEN-1:0] actual;
  } report_t;

  // First occurrence record, one per class
  typedef struct packed {
    logic            found;
    logic [XLEN-1:0] pc;
  } class_pc_t;

endpackage

`default_nettype wire

// ==== hw/trap_checker_top.sv ====
/*
  Top level of the trap checker. Connects the retirement and cause
  capture units, the single-step counter and the report FSM. Hook the
  retire and cause streams of the core to it and answer its reports.
*/

`timescale 1ns/100ps
`default_nettype none

module trap_checker_top import trap_check_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_ni,
  input  retire_t   retire_i,
  input  cause_wr_t cause_wr_i,
  input  wire logic step_i,
  input  wire logic debug_mode_i,
  input  wire logic report_ack_i,
  output report_t   report_o,
  output logic      report_req_o
);

  class_pc_t [NUM_CLASSES-1:0] exp_rec;
  class_pc_t [NUM_CLASSES-1:0] act_rec;
  logic                        step_overrun;
  logic                        step_clear;

  // Expected side, taken from the retiring instructions
  expect_capture expect_capture_i (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .retire_i  (retire_i),
    .exp_rec_o (exp_rec)
  );

  // Actual side, taken from what the core writes to mepc
  cause_capture cause_capture_i (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .cause_wr_i (cause_wr_i),
    .act_rec_o  (act_rec)
  );

  step_counter step_counter_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .retire_i       (retire_i),
    .step_i         (step_i),
    .debug_mode_i   (debug_mode_i),
    .step_clear_i   (step_clear),
    .step_overrun_o (step_overrun)
  );

  report_fsm report_fsm_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .exp_rec_i      (exp_rec),
    .act_rec_i      (act_rec),
    .step_overrun_i (step_overrun),
    .report_ack_i   (report_ack_i),
    .report_o       (report_o),
    .report_req_o   (report_req_o),
    .step_clear_o   (step_clear)
  );

endmodule

`default_nettype wire
